//--- src.f
+incdir+bench
verilog/board_video_pkg.sv
verilog/pixel_filter.sv
verilog/line_buffer.sv
verilog/scan_doubler.sv
verilog/video_board.sv
bench/video_board_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the video path testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module video_board_tb -f src.f -o video_board_sim \
    && ./obj_dir/video_board_sim | awk '{ print } /^Everything OK$/ { ok = 1 } END { exit !ok }' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- bench/tb_lines.svh
/*
    Line table for the video path testbench. Each row is one input line.
    Columns are bw_en, sl_mode, pixel seed and the expected second-copy
    level of the white pixel that ends the line.
    Needs board_video_pkg imported where it is included.
*/

`ifndef TB_LINES_SVH
`define TB_LINES_SVH

typedef struct packed {
    logic       bw_en;
    sl_mode_t   sl_mode;
    logic [7:0] seed;
    color8_t    white_lvl;
} line_row_t;

localparam int N_ROWS = 10;

// Two white pixels filter to 30 in either mode, which extends to 247
localparam line_row_t LINE_ROWS [N_ROWS] = '{
    '{1'b0, 2'd0, 8'h3a, 8'd247},
    '{1'b0, 2'd1, 8'h71, 8'd186},
    '{1'b0, 2'd2, 8'hc4, 8'd123},
    '{1'b0, 2'd3, 8'h05, 8'd61},
    '{1'b1, 2'd0, 8'h9e, 8'd247},
    '{1'b1, 2'd1, 8'h2b, 8'd186},
    '{1'b1, 2'd2, 8'he7, 8'd123},
    '{1'b1, 2'd3, 8'h50, 8'd61},
    '{1'b0, 2'd2, 8'hd9, 8'd123},
    '{1'b1, 2'd1, 8'h14, 8'd186}
};

`endif

//--- bench/video_board_tb.sv
/*
    Testbench for the board video path. Each table row is sent as one
    line of LINE_LEN pixels followed by BLANK_LEN blank samples.
    Every doubled output pixel is checked in order against a model.
    The run stops at the first error or at a cycle limit.
*/

`default_nettype none

module video_board_tb
    import board_video_pkg::*;
();

    localparam int BLANK_LEN    = 8;
    localparam int RESET_CYCLES = 16;

    `include "tb_lines.svh"

    localparam int CYCLE_LIMIT = (N_ROWS + 2) * (LINE_LEN + BLANK_LEN) * 4 + RESET_CYCLES;

    logic       clk_sys;
    logic       arst_n;
    logic       pxl_cen;
    logic       pxl2_cen;
    logic       bw_en;
    sl_mode_t   sl_mode;
    video_in_t  video_in;
    video_out_t video_out;

    logic [1:0] cen_cnt;
    logic       out_new = 1'b0;
    int         cycles = 0;
    rgb_in_t    line_pix [LINE_LEN];
    video_out_t exp_q [$];
    video_out_t exp_px;

    video_board i_dut (
        .clk_sys   ( clk_sys   ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .pxl2_cen  ( pxl2_cen  ),
        .video_in  ( video_in  ),
        .bw_en     ( bw_en     ),
        .sl_mode   ( sl_mode   ),
        .video_out ( video_out )
    );

    initial clk_sys = 1'b0;
    always #10 clk_sys = ~clk_sys;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int want);
        if (got != want) begin
            abort_run($sformatf("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h",
                                $time, name, got, want));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Filter, 8-bit extension and scanline shade of one channel
    function automatic color8_t ref_channel(input int cur, input int prv,
                                            input logic bw, input sl_mode_t mode);
        int filt;
        int full;
        int res;
        filt = bw ? cur + prv : 2 * cur;
        full = filt * 8 + filt / 4;
        case (mode)
            2'd1:    res = full - full / 4;
            2'd2:    res = full / 2;
            2'd3:    res = full / 4;
            default: res = full;
        endcase
        return color8_t'(res);
    endfunction

    // Expected pixels of one input line, plain copy then shaded copy
    task automatic queue_line(input line_row_t row);
        rgb_in_t    prv;
        sl_mode_t   mode;
        video_out_t e;
        for (int c = 0; c < 2; c++) begin
            mode = (c == 1) ? row.sl_mode : 2'd0;
            for (int i = 0; i < LINE_LEN; i++) begin
                if (i == 0) begin
                    prv = '0;
                end else begin
                    prv = line_pix[i-1];
                end
                e.r  = ref_channel(int'(line_pix[i].r), int'(prv.r), row.bw_en, mode);
                e.g  = ref_channel(int'(line_pix[i].g), int'(prv.g), row.bw_en, mode);
                e.b  = ref_channel(int'(line_pix[i].b), int'(prv.b), row.bw_en, mode);
                if (c == 1 && i == LINE_LEN - 1) begin
                    e.r = row.white_lvl;
                    e.g = row.white_lvl;
                    e.b = row.white_lvl;
                end
                e.de = 1'b1;
                e.sl = (c == 1);
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
        cen_cnt  = cen_cnt + 2'd1;
        pxl_cen  = (cen_cnt == 2'd0);
        pxl2_cen = ~cen_cnt[0];
    endtask

    // Sample is taken at the pxl_cen edge that ends this cycle
    task automatic send_sample(input video_in_t v);
        next_cycle();
        while (!pxl_cen) begin
            next_cycle();
        end
        video_in = v;
    endtask

    task automatic send_blank();
        video_in_t v;
        v      = '0;
        v.lvbl = 1'b1;
        send_sample(v);
    endtask

    task automatic send_line(input line_row_t row);
        logic [31:0] rng;
        video_in_t   v;
        rng = 32'd81 ^ {16'd0, row.seed, 8'd0};
        for (int i = 0; i < LINE_LEN; i++) begin
            rng = xorshift32(rng);
            // Two white pixels close every line
            if (i >= LINE_LEN - 2) begin
                line_pix[i] = 12'hfff;
            end else begin
                line_pix[i] = rng[11:0];
            end
            v.rgb  = line_pix[i];
            v.lhbl = 1'b1;
            v.lvbl = 1'b1;
            send_sample(v);
            if (i == 0) begin
                bw_en   = row.bw_en;
                sl_mode = row.sl_mode;
            end
        end
        queue_line(row);
        repeat (BLANK_LEN) begin
            send_blank();
        end
    endtask

    always @(posedge clk_sys) begin
        out_new <= pxl2_cen;
        cycles  <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout after %0d cycles, the run did not finish", cycles));
        end
    end

    // Output is stable at the falling edge after each pxl2_cen
    always @(negedge clk_sys) begin
        if (out_new && video_out.de) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("Output pixel at %0t with no input line behind it", $time));
            end else begin
                exp_px = exp_q.pop_front();
                check_value("video_out.r", int'(video_out.r), int'(exp_px.r));
                check_value("video_out.g", int'(video_out.g), int'(exp_px.g));
                check_value("video_out.b", int'(video_out.b), int'(exp_px.b));
                check_value("video_out.sl", int'(video_out.sl), int'(exp_px.sl));
            end
        end
    end

    initial begin
        arst_n   = 1'b0;
        pxl_cen  = 1'b0;
        pxl2_cen = 1'b0;
        cen_cnt  = 2'd3;
        bw_en    = 1'b0;
        sl_mode  = 2'd0;
        video_in = '0;
        repeat (RESET_CYCLES) begin
            next_cycle();
        end
        arst_n = 1'b1;
        repeat (2) begin
            send_blank();
        end
        for (int r = 0; r < N_ROWS; r++) begin
            send_line(LINE_ROWS[r]);
        end
        // Last output line ends within one more input line
        repeat (LINE_LEN + BLANK_LEN) begin
            send_blank();
        end
        if (exp_q.size() != 0) begin
            abort_run("Expected pixels were still waiting at the end of the run");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog/video_board.sv
/*
    Board video path. Filter, two-bank line buffer and scan doubler.
    pxl2_cen runs at twice the pxl_cen rate and coincides with every
    pxl_cen pulse. Blanking must last long enough for one output line
    to finish before the next input line completes.
*/

`default_nettype none

module video_board
    import board_video_pkg::*;
(
    input  logic       clk_sys,
    input  logic       arst_n,
    input  logic       pxl_cen,
    input  logic       pxl2_cen,
    input  video_in_t  video_in,
    input  logic       bw_en,
    input  sl_mode_t   sl_mode,
    output video_out_t video_out
);

    rgb_ana_t   ana;
    rgb_ana_t   rd_data;
    line_addr_t rd_addr;
    logic       ana_we;
    logic       line_end;
    logic       line_ready;

    pixel_filter u_filter (
        .clk_sys    ( clk_sys    ),
        .arst_n     ( arst_n     ),
        .pxl_cen    ( pxl_cen    ),
        .video_in   ( video_in   ),
        .bw_en      ( bw_en      ),
        .ana        ( ana        ),
        .ana_we     ( ana_we     ),
        .line_end   ( line_end   )
    );

    line_buffer u_buffer (
        .clk_sys    ( clk_sys    ),
        .arst_n     ( arst_n     ),
        .pxl_cen    ( pxl_cen    ),
        .ana        ( ana        ),
        .ana_we     ( ana_we     ),
        .line_end   ( line_end   ),
        .rd_addr    ( rd_addr    ),
        .rd_data    ( rd_data    ),
        .line_ready ( line_ready )
    );

    scan_doubler u_doubler (
        .clk_sys    ( clk_sys    ),
        .arst_n     ( arst_n     ),
        .pxl2_cen   ( pxl2_cen   ),
        .line_ready ( line_ready ),
        .sl_mode    ( sl_mode    ),
        .rd_addr    ( rd_addr    ),
        .rd_data    ( rd_data    ),
        .video_out  ( video_out  )
    );

endmodule

`default_nettype wire

//--- verilog/scan_doubler.sv
/*
    Scan doubler. Each line_ready starts a readout of the finished line,
    sent twice at pxl2_cen. The second copy can be dimmed as a scanline.
    pxl2_cen must not pulse on consecutive cycles, as the buffer read
    takes one clock. A new line_ready restarts the readout at once.
*/

`default_nettype none

module scan_doubler
    import board_video_pkg::*;
(
    input  logic       clk_sys,
    input  logic       arst_n,
    input  logic       pxl2_cen,
    input  logic       line_ready,
    input  sl_mode_t   sl_mode,
    output line_addr_t rd_addr,
    input  rgb_ana_t   rd_data,
    output video_out_t video_out
);

    typedef enum logic [1:0] {
        IDLE,
        FIRST_COPY,
        SECOND_COPY
    } state_t;

    state_t     state;
    line_addr_t addr_q;
    sl_mode_t   sl_q;
    sl_mode_t   dim_mode;
    video_out_t out_q;
    video_out_t pix_next;
    logic       at_last;
    logic       dim_on;

    // Repeat the top bits so that full scale maps to 8'hff
    function automatic color8_t extend8(input color_ana_t a);
        return {a, a[CLROUTW-1 -: 3]};
    endfunction

    function automatic color8_t shade(input color8_t v, input sl_mode_t mode);
        color8_t res;
        case (mode)
            SL_75:   res = v - (v >> 2);
            SL_50:   res = v >> 1;
            SL_25:   res = v >> 2;
            default: res = v;
        endcase
        return res;
    endfunction

    assign at_last  = (addr_q == line_addr_t'(LINE_LEN - 1));
    assign dim_on   = (state == SECOND_COPY);
    assign dim_mode = dim_on ? sl_q : SL_NONE;

    always_comb begin
        pix_next.r  = shade(extend8(rd_data.r), dim_mode);
        pix_next.g  = shade(extend8(rd_data.g), dim_mode);
        pix_next.b  = shade(extend8(rd_data.b), dim_mode);
        pix_next.de = 1'b1;
        pix_next.sl = dim_on;
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            addr_q <= '0;
            sl_q   <= SL_NONE;
        end else if (line_ready) begin
            // Address sits at zero so the first pixel is already read
            state  <= FIRST_COPY;
            addr_q <= '0;
            sl_q   <= sl_mode;
        end else if (pxl2_cen) begin
            case (state)
                FIRST_COPY: begin
                    addr_q <= at_last ? '0 : addr_q + line_addr_t'(1);
                    if (at_last) begin
                        state <= SECOND_COPY;
                    end
                end
                SECOND_COPY: begin
                    addr_q <= at_last ? '0 : addr_q + line_addr_t'(1);
                    if (at_last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state  <= IDLE;
                    addr_q <= '0;
                end
            endcase
        end
    end

    // Output pixel holds between pxl2_cen pulses
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            out_q <= '0;
        end else if (pxl2_cen) begin
            out_q <= (state == IDLE) ? '0 : pix_next;
        end
    end

    assign rd_addr   = addr_q;
    assign video_out = out_q;

endmodule

`default_nettype wire

//--- verilog/line_buffer.sv
/*
    Two-bank line store. The incoming line goes to the write bank while
    the other bank is read back with one clock of latency.
    Banks swap at line_end and line_ready follows one cycle later.
    Lines longer than LINE_LEN wrap over the start of the bank.
*/

`default_nettype none

module line_buffer
    import board_video_pkg::*;
(
    input  logic       clk_sys,
    input  logic       arst_n,
    input  logic       pxl_cen,
    input  rgb_ana_t   ana,
    input  logic       ana_we,
    input  logic       line_end,
    input  line_addr_t rd_addr,
    output rgb_ana_t   rd_data,
    output logic       line_ready
);

    rgb_ana_t   mem [2][LINE_LEN];
    line_addr_t wr_addr;
    logic       wr_sel;
    logic       rd_sel;
    logic       wr_en;

    assign wr_en  = ana_we & pxl_cen;
    assign rd_sel = ~wr_sel;

    // Write pointer and bank select
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            wr_addr    <= '0;
            wr_sel     <= 1'b0;
            line_ready <= 1'b0;
        end else begin
            if (line_end) begin
                wr_sel  <= ~wr_sel;
                wr_addr <= '0;
            end else if (wr_en) begin
                wr_addr <= wr_addr + line_addr_t'(1);
            end
            line_ready <= line_end;
        end
    end

    // Both banks start out black
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < LINE_LEN; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else if (wr_en) begin
            mem[wr_sel][wr_addr] <= ana;
        end
    end

    // Registered read from the finished bank
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_sel][rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/pixel_filter.sv
/*
    Bandwidth filter. Samples the game pixel at pxl_cen and presents the
    widened colour one pxl_cen later with ana_we. With bw_en set, each
    pixel is summed with the previous one of the same line.
    line_end pulses once at the first blank sample after active video.
*/

`default_nettype none

module pixel_filter
    import board_video_pkg::*;
(
    input  logic      clk_sys,
    input  logic      arst_n,
    input  logic      pxl_cen,
    input  video_in_t video_in,
    input  logic      bw_en,
    output rgb_ana_t  ana,
    output logic      ana_we,
    output logic      line_end
);

    rgb_in_t  prev_rgb;
    rgb_ana_t ana_next;
    rgb_ana_t ana_q;
    logic     in_active;
    logic     act_q;
    logic     act_qq;

    // Either twice the channel or the sum with its left neighbour
    function automatic color_ana_t widen(input color_t cur, input color_t prv,
                                         input logic blend);
        color_ana_t sum;
        if (blend) begin
            sum = {1'b0, cur} + {1'b0, prv};
        end else begin
            sum = {cur, 1'b0};
        end
        return sum;
    endfunction

    assign in_active = video_in.lhbl & video_in.lvbl;

    always_comb begin
        ana_next.r = widen(video_in.rgb.r, prev_rgb.r, bw_en);
        ana_next.g = widen(video_in.rgb.g, prev_rgb.g, bw_en);
        ana_next.b = widen(video_in.rgb.b, prev_rgb.b, bw_en);
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            prev_rgb <= '0;
            act_q    <= 1'b0;
            act_qq   <= 1'b0;
        end else if (pxl_cen) begin
            // Neighbour is zero at the start of every line
            prev_rgb <= in_active ? video_in.rgb : '0;
            act_q    <= in_active;
            act_qq   <= act_q;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            ana_q <= ana_next;
        end
    end

    assign ana      = ana_q;
    assign ana_we   = pxl_cen & act_q;
    assign line_end = pxl_cen & act_qq & ~act_q;

endmodule

`default_nettype wire

//--- verilog/board_video_pkg.sv
/*
    Shared widths, types and video structs for the board video path.
    LINE_LEN is kept small for simulation and must equal 2**LINE_AW.
    Colour channels widen from COLORW to COLORW+1 bits in the filter
    and are extended to 8 bits only at the scan doubler output.
*/

`default_nettype none

package board_video_pkg;

    // Game colour depth and the filtered depth
    localparam int COLORW  = 4;
    localparam int CLROUTW = COLORW + 1;

    // Active pixels per line and the matching address width
    localparam int LINE_LEN = 16;
    localparam int LINE_AW  = 4;

    typedef logic [COLORW-1:0]  color_t;
    typedef logic [CLROUTW-1:0] color_ana_t;
    typedef logic [7:0]         color8_t;
    typedef logic [LINE_AW-1:0] line_addr_t;

    // Scanline strength applied to the second copy of a line
    typedef logic [1:0] sl_mode_t;

    localparam sl_mode_t SL_NONE = 2'd0;
    localparam sl_mode_t SL_75   = 2'd1;
    localparam sl_mode_t SL_50   = 2'd2;
    localparam sl_mode_t SL_25   = 2'd3;

    // Game pixel as it leaves the core
    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_in_t;

    // Pixel after the bandwidth filter
    typedef struct packed {
        color_ana_t r;
        color_ana_t g;
        color_ana_t b;
    } rgb_ana_t;

    // Blanking flags are active low
    typedef struct packed {
        rgb_in_t rgb;
        logic    lhbl;
        logic    lvbl;
    } video_in_t;

    // Doubled output, sl marks the second copy of a line
    typedef struct packed {
        color8_t r;
        color8_t g;
        color8_t b;
        logic    de;
        logic    sl;
    } video_out_t;

endpackage

`default_nettype wire
